// File: i2s_timing_pkg.sv
//////////////////////////////
// timing constants for the I2S serializer and its testbench
// slot and frame sizes are fixed
// divider and buffer depth here are defaults only
//////////////////////////////

package i2s_timing_pkg;

    // one audio word
    localparam int SAMPLE_BITS = 16;

    // bit clocks per channel slot, delay bit + sample + padding
    localparam int SLOT_BITS = 32;

    // left slot then right slot
    localparam int FRAME_BITS = 2 * SLOT_BITS;

    // mclk cycles per bit clock, even and at least 2
    localparam int DEFAULT_MCLK_DIV = 4;

    // stereo pairs held ahead of the frame in flight
    localparam int DEFAULT_BUFFER_DEPTH = 2;

    localparam int FRAME_POS_W = $clog2(FRAME_BITS);
    typedef logic [FRAME_POS_W-1:0] frame_pos_t;

endpackage

// File: i2s_types_pkg.sv
//////////////////////////////
// sample type and the control enums
// sample width comes from the timing package
//////////////////////////////

package i2s_types_pkg;

    // signed pcm, two's complement
    typedef logic signed [i2s_timing_pkg::SAMPLE_BITS-1:0] sample_t;

    // frame sequencer
    // idle only until the first frame boundary after reset
    typedef enum logic [1:0] {
        FRAME_IDLE,
        FRAME_LEFT,
        FRAME_RIGHT
    } frame_state_e;

    // shifter commands, one per mclk cycle
    typedef enum logic [1:0] {
        SHIFT_HOLD,
        SHIFT_STEP,
        SHIFT_LOAD_LEFT,
        SHIFT_LOAD_RIGHT
    } shift_op_e;

endpackage

// File: i2s_bit_clock.sv
//////////////////////////////
// bit clock divider and frame bit counter
// MCLK_DIV must be even and at least 2
// sclk_fall is high in the last mclk of a bit period,
// sclk goes low on the edge that ends it
//////////////////////////////

module i2s_bit_clock
    import i2s_timing_pkg::*;
#(
    parameter int MCLK_DIV = DEFAULT_MCLK_DIV
) (
    input  logic       audgen_mclk,
    input  logic       reset_n,
    output logic       sclk,
    output logic       sclk_fall,
    output frame_pos_t frame_pos
);

    localparam int PHASE_W = $clog2(MCLK_DIV);
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(MCLK_DIV - 1);
    localparam logic [PHASE_W-1:0] PHASE_HIGH = PHASE_W'(MCLK_DIV / 2);
    localparam frame_pos_t POS_LAST = frame_pos_t'(FRAME_BITS - 1);
    localparam frame_pos_t POS_RESET = frame_pos_t'(FRAME_BITS - 2);

    logic [PHASE_W-1:0] phase;
    logic [PHASE_W-1:0] phase_nxt;
    logic               fall_next;

    // mclk phase within one bit period
    always_comb begin
        if (phase == PHASE_LAST) begin
            phase_nxt = '0;
        end else begin
            phase_nxt = phase + 1'b1;
        end
    end

    // next cycle is the last of the period
    assign fall_next = (phase_nxt == PHASE_LAST);

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            phase     <= '0;
            sclk      <= 1'b0;
            sclk_fall <= 1'b0;
            frame_pos <= POS_RESET;
        end else begin
            phase     <= phase_nxt;
            // low half first, high half second
            sclk      <= (phase_nxt >= PHASE_HIGH);
            sclk_fall <= fall_next;
            // position moves one cycle ahead of the strobe,
            // so the strobe sees the bit about to start
            if (fall_next) begin
                if (frame_pos == POS_LAST) begin
                    frame_pos <= '0;
                end else begin
                    frame_pos <= frame_pos + 1'b1;
                end
            end
        end
    end

endmodule

// File: i2s_frame_fsm.sv
//////////////////////////////
// frame sequencer
// decodes slot starts from frame_pos on sclk_fall
// shift_op and pop are combinational, valid in the strobe cycle
//////////////////////////////

module i2s_frame_fsm
    import i2s_timing_pkg::*;
    import i2s_types_pkg::*;
(
    input  logic       audgen_mclk,
    input  logic       reset_n,
    input  logic       sclk_fall,
    input  frame_pos_t frame_pos,
    output logic       pop,
    output logic       lrck,
    output shift_op_e  shift_op
);

    localparam frame_pos_t POS_LEFT = '0;
    localparam frame_pos_t POS_RIGHT = frame_pos_t'(SLOT_BITS);
    localparam frame_pos_t POS_LAST = frame_pos_t'(FRAME_BITS - 1);

    frame_state_e state;
    frame_state_e state_nxt;
    logic         left_start;
    logic         right_start;

    //////////////////////////////
    // boundary decode
    //////////////////////////////

    assign left_start = sclk_fall && (frame_pos == POS_LEFT);
    assign right_start = sclk_fall && (frame_pos == POS_RIGHT);

    // last bit of the frame, fetch the pair for the next one
    assign pop = sclk_fall && (frame_pos == POS_LAST);

    //////////////////////////////
    // state
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            FRAME_IDLE: begin
                if (left_start) begin
                    state_nxt = FRAME_LEFT;
                end
            end
            FRAME_LEFT: begin
                if (right_start) begin
                    state_nxt = FRAME_RIGHT;
                end
            end
            FRAME_RIGHT: begin
                if (left_start) begin
                    state_nxt = FRAME_LEFT;
                end
            end
            default: begin
                state_nxt = FRAME_IDLE;
            end
        endcase
    end

    // load at slot start, otherwise step once per bit
    always_comb begin
        shift_op = SHIFT_HOLD;
        if (left_start) begin
            shift_op = SHIFT_LOAD_LEFT;
        end else if (right_start) begin
            shift_op = SHIFT_LOAD_RIGHT;
        end else if (sclk_fall && (state != FRAME_IDLE)) begin
            shift_op = SHIFT_STEP;
        end
    end

    // lrck flips on the same edge as the shifter load
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            state <= FRAME_IDLE;
            lrck  <= 1'b0;
        end else begin
            state <= state_nxt;
            lrck  <= (state_nxt == FRAME_RIGHT);
        end
    end

endmodule

// File: i2s_sample_buffer.sv
//////////////////////////////
// stereo pair FIFO with valid/ready input
// sample_ready depends only on occupancy
// pop on an empty FIFO yields a silent pair
//////////////////////////////

module i2s_sample_buffer
    import i2s_timing_pkg::*;
    import i2s_types_pkg::*;
#(
    parameter int BUFFER_DEPTH = DEFAULT_BUFFER_DEPTH
) (
    input  logic    audgen_mclk,
    input  logic    reset_n,
    input  logic    sample_valid,
    output logic    sample_ready,
    input  sample_t sample_left,
    input  sample_t sample_right,
    input  logic    pop,
    output sample_t cur_left,
    output sample_t cur_right
);

    localparam int PTR_W = (BUFFER_DEPTH > 1) ? $clog2(BUFFER_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUFFER_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(BUFFER_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(BUFFER_DEPTH);

    sample_t          mem_left [BUFFER_DEPTH];
    sample_t          mem_right [BUFFER_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             take;

    // circular pointer step
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_LAST) begin
            return '0;
        end else begin
            return ptr + 1'b1;
        end
    endfunction

    assign sample_ready = (count != CNT_FULL);
    assign push = sample_valid && sample_ready;
    // pop only consumes an entry when one is there
    assign take = pop && (count != '0);

    // storage
    always_ff @(posedge audgen_mclk) begin
        if (push) begin
            mem_left[wr_ptr]  <= sample_left;
            mem_right[wr_ptr] <= sample_right;
        end
    end

    //////////////////////////////
    // pointers and occupancy
    //////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (take) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // pair for the next frame, silence on underrun
    always_ff @(posedge audgen_mclk) begin
        if (pop) begin
            if (take) begin
                cur_left  <= mem_left[rd_ptr];
                cur_right <= mem_right[rd_ptr];
            end else begin
                cur_left  <= '0;
                cur_right <= '0;
            end
        end
    end

endmodule

// File: i2s_shifter.sv
//////////////////////////////
// slot shift register for the I2S data line
// slot image is delay bit, sample MSB first, zero pad
//////////////////////////////

module i2s_shifter
    import i2s_timing_pkg::*;
    import i2s_types_pkg::*;
(
    input  logic      audgen_mclk,
    input  logic      reset_n,
    input  shift_op_e shift_op,
    input  sample_t   cur_left,
    input  sample_t   cur_right,
    output logic      dac
);

    localparam int PAD_BITS = SLOT_BITS - SAMPLE_BITS - 1;

    logic [SLOT_BITS-1:0] slot_sr;

    // one-bit I2S delay in front of the sample
    function automatic logic [SLOT_BITS-1:0] slot_image(input sample_t sample);
        return {1'b0, sample, {PAD_BITS{1'b0}}};
    endfunction

    //////////////////////////////
    // shift register
    //////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_sr <= '0;
        end else begin
            case (shift_op)
                SHIFT_LOAD_LEFT: begin
                    slot_sr <= slot_image(cur_left);
                end
                SHIFT_LOAD_RIGHT: begin
                    slot_sr <= slot_image(cur_right);
                end
                // towards the MSB, zeros fill the tail
                SHIFT_STEP: begin
                    slot_sr <= {slot_sr[SLOT_BITS-2:0], 1'b0};
                end
                default: begin
                    slot_sr <= slot_sr;
                end
            endcase
        end
    end

    // serial data is the register MSB
    assign dac = slot_sr[SLOT_BITS-1];

endmodule

// File: audio_i2s_top.sv
//////////////////////////////
// I2S serializer top, all logic on audgen_mclk
// MCLK_DIV even and at least 2, BUFFER_DEPTH at least 1
//////////////////////////////

module audio_i2s_top
    import i2s_timing_pkg::*;
    import i2s_types_pkg::*;
#(
    parameter int MCLK_DIV     = DEFAULT_MCLK_DIV,
    parameter int BUFFER_DEPTH = DEFAULT_BUFFER_DEPTH
) (
    input  logic    audgen_mclk,
    input  logic    reset_n,
    input  logic    sample_valid,
    output logic    sample_ready,
    input  sample_t sample_left,
    input  sample_t sample_right,
    output logic    audio_sclk,
    output logic    audio_lrck,
    output logic    audio_dac
);

    logic       sclk_fall;
    frame_pos_t frame_pos;
    logic       pop;
    shift_op_e  shift_op;
    sample_t    cur_left;
    sample_t    cur_right;

    // bit clock and frame position
    i2s_bit_clock #(
        .MCLK_DIV (MCLK_DIV)
    ) i_bit_clock (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .sclk        (audio_sclk),
        .sclk_fall   (sclk_fall),
        .frame_pos   (frame_pos)
    );

    // sequencing of pops, lrck and shifter commands
    i2s_frame_fsm i_frame_fsm (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .sclk_fall   (sclk_fall),
        .frame_pos   (frame_pos),
        .pop         (pop),
        .lrck        (audio_lrck),
        .shift_op    (shift_op)
    );

    i2s_sample_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) i_sample_buffer (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .pop          (pop),
        .cur_left     (cur_left),
        .cur_right    (cur_right)
    );

    i2s_shifter i_shifter (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .shift_op    (shift_op),
        .cur_left    (cur_left),
        .cur_right   (cur_right),
        .dac         (audio_dac)
    );

endmodule

// File: audio_i2s_chk.sv
//////////////////////////////
// protocol assertions on audio_i2s_top, attached by bind
// all properties sampled on audgen_mclk
//////////////////////////////

module audio_i2s_chk
    import i2s_types_pkg::*;
(
    input logic    audgen_mclk,
    input logic    reset_n,
    input logic    sample_valid,
    input logic    sample_ready,
    input sample_t sample_left,
    input sample_t sample_right,
    input logic    audio_sclk,
    input logic    audio_lrck,
    input logic    audio_dac
);

    // lrck and data move only with a falling bit clock
    a_edge_align: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        ($changed(audio_lrck) || $changed(audio_dac)) |-> $fell(audio_sclk)
    ) else $error("audio_lrck or audio_dac changed while audio_sclk did not fall");

    // outputs quiet in reset
    a_reset_quiet: assert property (
        @(posedge audgen_mclk)
        !reset_n |-> (!audio_sclk && !audio_lrck && !audio_dac)
    ) else $error("audio output high during reset");

    // an offer is held until it is taken
    a_hold_offer: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        (sample_valid && !sample_ready) |=>
            (sample_valid && $stable(sample_left) && $stable(sample_right))
    ) else $error("sample offer dropped or changed while sample_ready was low");

endmodule

bind audio_i2s_top audio_i2s_chk i_chk (
    .audgen_mclk  (audgen_mclk),
    .reset_n      (reset_n),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .sample_left  (sample_left),
    .sample_right (sample_right),
    .audio_sclk   (audio_sclk),
    .audio_lrck   (audio_lrck),
    .audio_dac    (audio_dac)
);

// File: tb_audio_i2s.sv
//////////////////////////////
// directed testbench for audio_i2s_top with default parameters
// receiver rebuilds slots from audio_dac at audio_sclk rising edges
// every wait is bounded, a timeout counts as an error
//////////////////////////////

module tb_audio_i2s
    import i2s_timing_pkg::*;
    import i2s_types_pkg::*;
();

    localparam int DRIVE_DELAY = 10;
    localparam int FRAME_TIMEOUT = 2 * FRAME_BITS * DEFAULT_MCLK_DIV;
    localparam int SEND_TIMEOUT = 4 * FRAME_BITS * DEFAULT_MCLK_DIV;
    localparam int STREAM_PAIRS = 20;
    localparam int BP_PAIRS = 5;

    logic    audgen_mclk;
    logic    reset_n;
    logic    sample_valid;
    logic    sample_ready;
    sample_t sample_left;
    sample_t sample_right;
    logic    audio_sclk;
    logic    audio_lrck;
    logic    audio_dac;

    logic [31:0] rng_state;
    string       cur_test;
    int          tests;
    int          failed_tests;
    int          checks;
    int          errors;
    int          test_start_errors;
    // expected pairs, in send order
    sample_t     stream_left[$];
    sample_t     stream_right[$];

    audio_i2s_top i_dut (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .audio_sclk   (audio_sclk),
        .audio_lrck   (audio_lrck),
        .audio_dac    (audio_dac)
    );

    initial begin
        audgen_mclk = 1'b0;
        forever #50 audgen_mclk = ~audgen_mclk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // xorshift32, low half as one sample
    function automatic sample_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return sample_t'(rng_state[15:0]);
    endfunction

    // slot bits 1..16 are the sample, MSB first
    function automatic sample_t slot_sample(input logic [FRAME_BITS-1:0] bits, input int base);
        logic [FRAME_BITS-1:0] tmp;
        sample_t               s;
        int                    i;
        tmp = bits >> (base + 1);
        s = '0;
        for (i = 0; i < SAMPLE_BITS; i++) begin
            s = {s[SAMPLE_BITS-2:0], tmp[0]};
            tmp = tmp >> 1;
        end
        return s;
    endfunction

    // ones on the delay bit or the padding of either slot
    function automatic int pad_ones(input logic [FRAME_BITS-1:0] bits);
        logic [FRAME_BITS-1:0] tmp;
        int                    k;
        int                    n;
        tmp = bits;
        n = 0;
        for (k = 0; k < FRAME_BITS; k++) begin
            if (((k % SLOT_BITS) == 0 || (k % SLOT_BITS) > SAMPLE_BITS) && tmp[0]) begin
                n++;
            end
            tmp = tmp >> 1;
        end
        return n;
    endfunction

    // inputs change and outputs are read here
    task automatic tick();
        @(posedge audgen_mclk);
        #DRIVE_DELAY;
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error in %s: %s", cur_test, msg);
    endtask

    task automatic check_sample(input string what, input sample_t expected, input sample_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: %s expected %h actual %h", cur_test, what, expected, actual);
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: %s expected %b actual %b", cur_test, what, expected, actual);
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("Fail %s: %s expected %0d actual %0d", cur_test, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_start_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == test_start_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", cur_test, errors - test_start_errors);
        end
    endtask

    // offer one pair, hold it until taken
    task automatic send_pair(input sample_t left, input sample_t right);
        int cyc;
        bit done;
        done = 1'b0;
        sample_valid = 1'b1;
        sample_left = left;
        sample_right = right;
        for (cyc = 0; cyc < SEND_TIMEOUT && !done; cyc++) begin
            // ready seen now is what the next edge uses
            done = sample_ready;
            tick();
        end
        sample_valid = 1'b0;
        if (!done) begin
            report_error("timed out waiting for sample_ready");
        end
    endtask

    task automatic wait_lrck_fall(output bit ok);
        logic prev;
        int   cyc;
        ok = 1'b0;
        prev = audio_lrck;
        for (cyc = 0; cyc < FRAME_TIMEOUT && !ok; cyc++) begin
            tick();
            ok = prev && !audio_lrck;
            prev = audio_lrck;
        end
        if (!ok) begin
            report_error("timed out waiting for an audio_lrck falling edge");
        end
    endtask

    // one frame, from just after an lrck fall up to the next one
    task automatic capture_frame(output logic [FRAME_BITS-1:0] bits, output int rises,
                                 output int lrck_rise_at, output bit ok);
        logic prev_sclk;
        logic prev_lrck;
        int   cyc;
        ok = 1'b0;
        bits = '0;
        rises = 0;
        lrck_rise_at = -1;
        prev_sclk = audio_sclk;
        prev_lrck = audio_lrck;
        for (cyc = 0; cyc < FRAME_TIMEOUT && !ok; cyc++) begin
            tick();
            if (!prev_sclk && audio_sclk) begin
                // first bit ends at index 0 after a full frame
                if (rises < FRAME_BITS) begin
                    bits = {audio_dac, bits[FRAME_BITS-1:1]};
                end
                rises++;
            end
            if (!prev_lrck && audio_lrck) begin
                lrck_rise_at = rises;
            end
            ok = prev_lrck && !audio_lrck;
            prev_sclk = audio_sclk;
            prev_lrck = audio_lrck;
        end
        if (!ok) begin
            report_error("timed out waiting for the end of a frame");
        end
    endtask

    // leading silent frames skipped, then every queued pair in order
    task automatic receive_stream(input int n);
        logic [FRAME_BITS-1:0] bits;
        int                    rises;
        int                    rise_at;
        int                    idx;
        int                    skipped;
        bit                    ok;
        sample_t               l;
        sample_t               r;
        idx = 0;
        skipped = 0;
        while (idx < n) begin
            capture_frame(bits, rises, rise_at, ok);
            if (!ok) begin
                return;
            end
            l = slot_sample(bits, 0);
            r = slot_sample(bits, SLOT_BITS);
            if (idx == 0 && l == '0 && r == '0) begin
                skipped++;
                if (skipped > 3) begin
                    report_error("first pair never appeared on audio_dac");
                    return;
                end
            end else begin
                check_sample($sformatf("pair %0d left", idx), stream_left[idx], l);
                check_sample($sformatf("pair %0d right", idx), stream_right[idx], r);
                check_count($sformatf("pair %0d padding ones", idx), 0, pad_ones(bits));
                idx++;
            end
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_reset();
        begin_test("reset");
        repeat (8) tick();
        check_bit("sclk in reset", 1'b0, audio_sclk);
        check_bit("lrck in reset", 1'b0, audio_lrck);
        check_bit("dac in reset", 1'b0, audio_dac);
        check_bit("ready in reset", 1'b1, sample_ready);
        repeat (8) tick();
        reset_n = 1'b1;
        tick();
        check_bit("sclk after reset", 1'b0, audio_sclk);
        check_bit("lrck after reset", 1'b0, audio_lrck);
        check_bit("dac after reset", 1'b0, audio_dac);
        check_bit("ready after reset", 1'b1, sample_ready);
        end_test();
    endtask

    task automatic test_silence();
        logic [FRAME_BITS-1:0] bits;
        int                    rises;
        int                    rise_at;
        int                    f;
        bit                    ok;
        begin_test("silence");
        wait_lrck_fall(ok);
        for (f = 0; f < 2 && ok; f++) begin
            capture_frame(bits, rises, rise_at, ok);
            check_count("sclk rises per frame", FRAME_BITS, rises);
            check_count("sclk rises before lrck rise", SLOT_BITS, rise_at);
            check_sample("left", sample_t'(0), slot_sample(bits, 0));
            check_sample("right", sample_t'(0), slot_sample(bits, SLOT_BITS));
            check_count("padding ones", 0, pad_ones(bits));
        end
        end_test();
    endtask

    task automatic test_one_pair();
        logic [FRAME_BITS-1:0] bits;
        int                    rises;
        int                    rise_at;
        int                    f;
        bit                    ok;
        bit                    found;
        sample_t               l;
        sample_t               r;
        begin_test("one_pair");
        l = next_random();
        r = next_random();
        // a nonzero left word tells the pair from silence
        if (l == '0) begin
            l = sample_t'(1);
        end
        send_pair(l, r);
        wait_lrck_fall(ok);
        found = 1'b0;
        for (f = 0; f < 3 && ok && !found; f++) begin
            capture_frame(bits, rises, rise_at, ok);
            found = (slot_sample(bits, 0) != '0) || (slot_sample(bits, SLOT_BITS) != '0);
        end
        if (!found) begin
            report_error("pair never appeared on audio_dac");
        end else begin
            check_sample("left", l, slot_sample(bits, 0));
            check_sample("right", r, slot_sample(bits, SLOT_BITS));
            check_count("padding ones", 0, pad_ones(bits));
            // nothing queued behind it
            capture_frame(bits, rises, rise_at, ok);
            check_sample("next left", sample_t'(0), slot_sample(bits, 0));
            check_sample("next right", sample_t'(0), slot_sample(bits, SLOT_BITS));
        end
        end_test();
    endtask

    task automatic test_stream();
        int i;
        bit ok;
        begin_test("stream");
        stream_left.delete();
        stream_right.delete();
        for (i = 0; i < STREAM_PAIRS; i++) begin
            stream_left.push_back(next_random());
            stream_right.push_back(next_random());
        end
        wait_lrck_fall(ok);
        fork
            begin
                for (i = 0; i < STREAM_PAIRS; i++) begin
                    send_pair(stream_left[i], stream_right[i]);
                end
            end
            receive_stream(STREAM_PAIRS);
        join
        end_test();
    endtask

    task automatic test_backpressure();
        int i;
        int accepted;
        bit ok;
        begin_test("backpressure");
        stream_left.delete();
        stream_right.delete();
        for (i = 0; i < BP_PAIRS; i++) begin
            stream_left.push_back(next_random());
            stream_right.push_back(next_random());
        end
        wait_lrck_fall(ok);
        fork
            begin
                // fill until the buffer pushes back
                accepted = 0;
                sample_valid = 1'b1;
                sample_left = stream_left[0];
                sample_right = stream_right[0];
                while (sample_ready && accepted < BP_PAIRS) begin
                    tick();
                    accepted++;
                    if (accepted < BP_PAIRS) begin
                        sample_left = stream_left[accepted];
                        sample_right = stream_right[accepted];
                    end else begin
                        sample_valid = 1'b0;
                    end
                end
                check_bit("ready when full", 1'b0, sample_ready);
                // a pop in the fill window may take one more
                if (accepted > DEFAULT_BUFFER_DEPTH) begin
                    check_count("pairs before ready fell", DEFAULT_BUFFER_DEPTH + 1, accepted);
                end else begin
                    check_count("pairs before ready fell", DEFAULT_BUFFER_DEPTH, accepted);
                end
                for (i = accepted; i < BP_PAIRS; i++) begin
                    send_pair(stream_left[i], stream_right[i]);
                end
            end
            receive_stream(BP_PAIRS);
        join
        end_test();
    endtask

    //////////////////////////////
    // sequence
    //////////////////////////////

    initial begin
        sample_valid = 1'b0;
        sample_left = '0;
        sample_right = '0;
        rng_state = 32'd43;
        tests = 0;
        failed_tests = 0;
        checks = 0;
        errors = 0;
        // clean falling edge of reset at time 1
        reset_n = 1'b1;
        #1;
        reset_n = 1'b0;
        test_reset();
        test_silence();
        test_one_pair();
        test_stream();
        test_backpressure();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
i2s_timing_pkg.sv
i2s_types_pkg.sv
i2s_bit_clock.sv
i2s_frame_fsm.sv
i2s_sample_buffer.sv
i2s_shifter.sv
audio_i2s_top.sv
audio_i2s_chk.sv
tb_audio_i2s.sv

// File: run_sim.sh
#!/bin/sh
# build and run the I2S serializer testbench with Verilator
# the result is read from the simulation log

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_audio_i2s -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** TEST FAILED ***' "$LOG"; then
    exit 1
fi
if ! grep -qF '*** TEST PASSED ***' "$LOG"; then
    echo "simulation log has no result line"
    exit 1
fi
exit 0
